// File: files.f
+incdir+.
pcsSyncPkg.sv
pcsRxPkg.sv
codeGroupIf.sv
pcsSync.sv
pcsReceive.sv
pcsRx.sv
tbClkGen.sv
pcsRx_props.sv
pcsRx_tb.sv

// File: Makefile
SRCS := $(shell grep -v '^+' files.f) pcs_consts.svh

.PHONY: run clean

run: obj_dir/VpcsRx_tb
	./obj_dir/VpcsRx_tb > sim.log 2>&1 || true
	@cat sim.log
	@! grep -q '\*\*\* TEST FAILED \*\*\*' sim.log
	@grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

obj_dir/VpcsRx_tb: $(SRCS) files.f
	verilator --binary --timing --assert --top-module pcsRx_tb -f files.f -o VpcsRx_tb

clean:
	rm -rf obj_dir sim.log

// File: pcsRx_trace.txt
# rep sd lb cke ctrl inv byte  mask sync slip dv er rxd cfgv cfgw idle  (rep 0 = random idle filler)
# mask bits 0..7 select sync slip dv er rxd cfgv cfgw; expected outputs already include latency
14 1 0 1 0 0 00  BF 0 0 0 0 00 0 0000 0
1  1 0 1 1 0 BC  BF 0 1 0 0 00 0 0000 0
2  1 0 1 0 0 4A  BF 0 0 0 0 00 0 0000 0
1  1 0 1 1 0 BC  BF 0 0 0 0 00 0 0000 0
1  1 0 1 0 0 4A  BF 0 0 0 0 00 0 0000 0
1  1 0 1 1 0 BC  BF 0 0 0 0 00 0 0000 0
1  1 0 1 0 0 4A  BF 0 0 0 0 00 0 0000 0
1  1 0 1 1 0 BC  BF 0 0 0 0 00 0 0000 0
1  1 0 1 0 0 4A  BF 0 0 0 0 00 0 0000 0
1  1 0 1 1 0 BC  BF 0 0 0 0 00 0 0000 0
1  1 0 1 0 0 4A  BF 0 0 0 0 00 0 0000 0
1  1 0 1 1 0 BC  BF 0 0 0 0 00 0 0000 0
1  1 0 1 0 0 50  BF 1 0 0 0 00 0 0000 0
1  1 0 1 1 0 BC  BF 1 0 0 0 00 0 0000 0
1  1 0 1 0 0 50  BF 1 0 0 0 00 0 0000 1
0  0 0 0 0 0 00  00 0 0 0 0 00 0 0000 0
# frame with an error byte
1  1 0 1 1 0 FB  BF 1 0 0 0 00 0 0000 1
1  1 0 1 0 0 11  BF 1 0 0 0 00 0 0000 1
1  1 0 1 0 0 22  BF 1 0 1 0 55 0 0000 0
1  1 0 1 1 0 FE  BF 1 0 1 0 11 0 0000 0
1  1 0 1 0 0 33  BF 1 0 1 0 22 0 0000 0
1  1 0 1 1 0 FD  BF 1 0 1 1 FE 0 0000 0
1  1 0 1 1 0 BC  BF 1 0 1 0 33 0 0000 0
1  1 0 1 0 0 50  BF 1 0 0 0 00 0 0000 0
# config word 1234, then clock enable held low
1  1 0 1 1 0 BC  BF 1 0 0 0 00 0 0000 0
1  1 0 1 0 0 B5  BF 1 0 0 0 00 0 0000 1
1  1 0 1 0 0 34  BF 1 0 0 0 00 0 0000 1
1  1 0 1 0 0 12  BF 1 0 0 0 00 0 0000 0
1  1 0 1 1 0 BC  BF 1 0 0 0 00 0 0000 0
1  1 0 1 0 0 50  FF 1 0 0 0 00 1 1234 0
3  1 0 0 0 0 00  FF 1 0 0 0 00 0 1234 0
1  1 0 1 1 0 BC  FF 1 0 0 0 00 0 1234 0
1  1 0 1 0 0 50  FF 1 0 0 0 00 0 1234 1
# four invalid groups drop sync, then reacquire
4  1 0 1 0 1 00  FF 1 0 0 0 00 0 1234 1
1  1 0 1 0 0 00  FF 1 0 0 0 00 0 1234 1
1  1 0 1 0 0 00  FF 0 0 0 0 00 0 1234 1
1  1 0 1 1 0 BC  FF 0 0 0 0 00 0 1234 0
1  1 0 1 0 0 4A  FF 0 0 0 0 00 0 1234 0
1  1 0 1 1 0 BC  FF 0 0 0 0 00 0 1234 0
1  1 0 1 0 0 4A  FF 0 0 0 0 00 0 1234 0
1  1 0 1 1 0 BC  FF 0 0 0 0 00 0 1234 0
1  1 0 1 0 0 4A  FF 0 0 0 0 00 0 1234 0
# signal detect drops under loopback, then rises without it
1  0 1 1 1 0 BC  FF 0 0 0 0 00 0 1234 0
1  0 1 1 0 0 4A  FF 1 0 0 0 00 0 1234 0
1  1 0 1 0 0 4A  FF 1 0 0 0 00 0 1234 0
1  1 0 1 0 0 4A  FF 1 0 0 0 00 0 1234 0
3  1 0 1 0 0 4A  FF 0 0 0 0 00 0 1234 0

// File: pcsRx_tb.sv
// pcs receive testbench: replays the code-group trace and compares every output
`timescale 1ns/1ps
`include "pcs_consts.svh"
`default_nettype none

module pcsRx_tb;

	localparam int MaxLines = 128;

	logic        i_Clk;
	logic        i_ARst_L;
	logic        i_Cke;
	logic        i_CtrlLoopBack;
	logic        i_SignalDetect;
	logic [7:0]  i8_RxCodeGroup;
	logic        i_RxCodeCtrl;
	logic        i_RxCodeInvalid;
	wire         o_SyncStatus;
	wire         o_RxEven;
	wire         o_BitSlip;
	wire         o_RxDv;
	wire         o_RxEr;
	wire  [7:0]  o8_Rxd;
	wire  [15:0] o16_ConfigWord;
	wire         o_ConfigValid;
	wire         o_RxIdle;

	// columns: rep sd lb cke ctrl inv byte mask sync slip dv er rxd cfgv cfgw idle
	int trc [MaxLines][16];
	int nLines = 0;
	int limit = 0;
	int cycles = 0;
	int checks = 0;
	int errors = 0;

	logic expEven = 1'b0;   // parity of the last clocked-in group
	logic heldCke = 1'b1;   // enable of the group waiting for the next edge
	logic heldComma = 1'b0;

	tbClkGen tbClkGen_i (.o_Clk(i_Clk), .o_ARst_L(i_ARst_L));

	pcsRx pcsRx_i (.*);

	function automatic int loadTrace();
		int fd;
		int code;
		int f [16];
		reg [8*256-1:0] rest;
		fd = $fopen("pcsRx_trace.txt", "r");
		if (fd == 0)
			return 0;
		while (!$feof(fd) && nLines < MaxLines) begin
			code = $fscanf(fd, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
				f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
			if (code == -1)
				break;
			if (code == 16) begin
				trc[nLines] = f;
				nLines++;
			end else begin
				code = $fgets(rest, fd); // comment line
			end
		end
		$fclose(fd);
		return 1;
	endfunction

	task automatic compareField(input string name, input logic [15:0] got,
		input logic [15:0] exp, input int line);
		checks++;
		assert (got === exp) else begin
			$display("error %s at trace line %0d: got 0x%h, expected 0x%h", name, line, got, exp);
			errors++;
		end
	endtask

	task automatic driveGroup(input logic sd, input logic lb, input logic cke,
		input logic ctrl, input logic inv, input logic [7:0] cg);
		@(posedge i_Clk);
		if (heldCke)
			expEven = heldComma ? 1'b1 : ~expEven; // a comma marks an even position
		i_SignalDetect <= sd;
		i_CtrlLoopBack <= lb;
		i_Cke <= cke;
		i_RxCodeCtrl <= ctrl;
		i_RxCodeInvalid <= inv;
		i8_RxCodeGroup <= cg;
		heldCke = cke;
		heldComma = ctrl && !inv && cg == `K28_5;
		@(negedge i_Clk);
	endtask

	// in sync the parity just alternates, commas landing on even groups
	task automatic checkEven(input int line);
		compareField("o_RxEven", {15'd0, o_RxEven}, {15'd0, expEven}, line);
	endtask

	task automatic checkOutputs(input int i);
		int m;
		m = trc[i][7];
		if (m[0]) compareField("o_SyncStatus", {15'd0, o_SyncStatus}, trc[i][8][15:0], i);
		if (m[0] && trc[i][8][0]) checkEven(i);
		if (m[1]) compareField("o_BitSlip", {15'd0, o_BitSlip}, trc[i][9][15:0], i);
		if (m[2]) compareField("o_RxDv", {15'd0, o_RxDv}, trc[i][10][15:0], i);
		if (m[3]) compareField("o_RxEr", {15'd0, o_RxEr}, trc[i][11][15:0], i);
		if (m[4]) compareField("o8_Rxd", {8'd0, o8_Rxd}, trc[i][12][15:0], i);
		if (m[5]) compareField("o_ConfigValid", {15'd0, o_ConfigValid}, trc[i][13][15:0], i);
		if (m[6]) compareField("o16_ConfigWord", o16_ConfigWord, trc[i][14][15:0], i);
		if (m[7]) compareField("o_RxIdle", {15'd0, o_RxIdle}, trc[i][15][15:0], i);
	endtask

	// /I2/ pairs keep the link idle, only sync status is watched
	task automatic runFiller(input logic expSync, input int i);
		int pairs;
		pairs = $urandom % 4 + 1;
		repeat (pairs) begin
			driveGroup(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, `K28_5);
			compareField("o_SyncStatus", {15'd0, o_SyncStatus}, {15'd0, expSync}, i);
			if (expSync) checkEven(i);
			driveGroup(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, `D16_2);
			compareField("o_SyncStatus", {15'd0, o_SyncStatus}, {15'd0, expSync}, i);
			if (expSync) checkEven(i);
		end
	endtask

	always @(posedge i_Clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		int ok;
		int total;
		logic lastSync;
		i_Cke = 1'b1;
		i_CtrlLoopBack = 1'b0;
		i_SignalDetect = 1'b1;
		i8_RxCodeGroup = 8'h00;
		i_RxCodeCtrl = 1'b0;
		i_RxCodeInvalid = 1'b0;
		void'($urandom(32'h2f100227));
		lastSync = 1'b0;
		total = 0;
		ok = loadTrace();
		if (ok == 0 || nLines == 0) begin
			$display("could not read the trace file pcsRx_trace.txt");
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			for (int i = 0; i < nLines; i++)
				total += (trc[i][0] == 0) ? 8 : trc[i][0]; // filler is at most 4 pairs
			limit = 4 * total + 8;
			wait (i_ARst_L === 1'b1);
			for (int i = 0; i < nLines; i++) begin
				if (trc[i][0] == 0) begin
					runFiller(lastSync, i);
				end else begin
					for (int r = 0; r < trc[i][0]; r++) begin
						driveGroup(trc[i][1][0], trc[i][2][0], trc[i][3][0],
							trc[i][4][0], trc[i][5][0], trc[i][6][7:0]);
						checkOutputs(i);
					end
					lastSync = trc[i][8][0];
				end
			end
			$display("checks: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("*** TEST PASSED ***");
			else
				$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: pcsRx_props.sv
// pcs receive properties: output consistency rules checked on every clock
`timescale 1ns/1ps
`default_nettype none

module pcsRx_props (
	input wire i_Clk,
	input wire i_ARst_L,
	input wire i_SyncStatus,
	input wire i_BitSlip,
	input wire i_RxDv,
	input wire i_ConfigValid
);

	// a frame can only be delivered while in sync
	assert property (@(posedge i_Clk) disable iff (!i_ARst_L) i_RxDv |-> i_SyncStatus)
		else $error("rx data valid seen while sync status is low");

	assert property (@(posedge i_Clk) disable iff (!i_ARst_L) i_BitSlip |-> !i_SyncStatus)
		else $error("bit slip requested while in sync");

	// config capture and frame data are exclusive receive states
	assert property (@(posedge i_Clk) disable iff (!i_ARst_L) !(i_ConfigValid && i_RxDv))
		else $error("config valid and rx data valid high together");

endmodule

bind pcsRx pcsRx_props pcsRx_props_i (
	.i_Clk         (i_Clk),
	.i_ARst_L      (i_ARst_L),
	.i_SyncStatus  (o_SyncStatus),
	.i_BitSlip     (o_BitSlip),
	.i_RxDv        (o_RxDv),
	.i_ConfigValid (o_ConfigValid)
);

`default_nettype wire

// File: tbClkGen.sv
// testbench clock and reset source: 10 ns clock, reset held low for 8 cycles
`timescale 1ns/1ps
`default_nettype none

module tbClkGen (
	output logic o_Clk,
	output logic o_ARst_L
);

	initial begin
		o_Clk = 1'b0;
		forever #5 o_Clk = ~o_Clk;
	end

	initial begin
		o_ARst_L = 1'b0;
		repeat (8) @(posedge o_Clk);
		@(negedge o_Clk);
		o_ARst_L = 1'b1; // released away from the rising edge
	end

endmodule

`default_nettype wire

// File: pcsRx.sv
// pcs receive top: code-group sync followed by gmii rebuild and config capture
`timescale 1ns/1ps
`default_nettype none

module pcsRx (
	input  wire         i_Clk,
	input  wire         i_ARst_L,
	input  wire         i_Cke,
	input  wire         i_CtrlLoopBack,
	input  wire         i_SignalDetect,
	input  wire  [7:0]  i8_RxCodeGroup,
	input  wire         i_RxCodeCtrl,
	input  wire         i_RxCodeInvalid,
	output wire         o_SyncStatus,
	output wire         o_RxEven,
	output wire         o_BitSlip,
	output wire         o_RxDv,
	output wire         o_RxEr,
	output wire  [7:0]  o8_Rxd,
	output wire  [15:0] o16_ConfigWord,
	output wire         o_ConfigValid,
	output wire         o_RxIdle
);

	codeGroupIf cgBus ();

	pcsSync pcsSync_i (
		.i_Clk           (i_Clk),
		.i_ARst_L        (i_ARst_L),
		.i_Cke           (i_Cke),
		.i_CtrlLoopBack  (i_CtrlLoopBack),
		.i_SignalDetect  (i_SignalDetect),
		.i8_RxCodeGroup  (i8_RxCodeGroup),
		.i_RxCodeCtrl    (i_RxCodeCtrl),
		.i_RxCodeInvalid (i_RxCodeInvalid),
		.o_BitSlip       (o_BitSlip),
		.o_CodeGroup     (cgBus.syncSide)
	);

	pcsReceive pcsReceive_i (
		.i_Clk          (i_Clk),
		.i_ARst_L       (i_ARst_L),
		.i_Cke          (i_Cke),
		.i_CodeGroup    (cgBus.rxSide),
		.o_RxDv         (o_RxDv),
		.o_RxEr         (o_RxEr),
		.o8_Rxd         (o8_Rxd),
		.o16_ConfigWord (o16_ConfigWord),
		.o_ConfigValid  (o_ConfigValid),
		.o_RxIdle       (o_RxIdle)
	);

	assign o_SyncStatus = cgBus.sync; // status and parity come straight off the link
	assign o_RxEven = cgBus.even;

endmodule

`default_nettype wire

// File: pcsReceive.sv
// pcs receive: gmii stream rebuild from ordered sets and auto-negotiation word capture
`timescale 1ns/1ps
`include "pcs_consts.svh"
`default_nettype none

module pcsReceive (
	input  wire         i_Clk,
	input  wire         i_ARst_L,
	input  wire         i_Cke,
	codeGroupIf.rxSide  i_CodeGroup,
	output logic        o_RxDv,
	output logic        o_RxEr,
	output logic [7:0]  o8_Rxd,
	output logic [15:0] o16_ConfigWord,
	output logic        o_ConfigValid,
	output logic        o_RxIdle
);
	import pcsRxPkg::*;

	RxState_t   r_State;
	RxState_t   w_NextState;
	logic [7:0] r8_CfgLow; // low byte of the word in progress
	logic       w_IsData;
	logic       w_Dv;
	logic       w_Er;
	logic [7:0] w8_Rxd;
	logic       w_CfgValid;
	logic       w_LoadLow;
	logic       w_Idle;

	assign w_IsData = ~i_CodeGroup.ctrl & ~i_CodeGroup.invalid;

	always_comb begin
		w_NextState = r_State;
		w_Dv = 1'b0;
		w_Er = 1'b0;
		w8_Rxd = 8'h00;
		w_CfgValid = 1'b0;
		w_LoadLow = 1'b0;
		if (!i_CodeGroup.sync) begin
			w_NextState = rxIdle; // everything stays low until sync returns
		end else begin
			case (r_State)
			rxIdle: begin
				if (i_CodeGroup.kind == osS) begin
					w_NextState = rxFrame;
					w_Dv = 1'b1;
					w8_Rxd = `PCS_PREAMBLE;
				end else if (i_CodeGroup.kind == osC1 || i_CodeGroup.kind == osC2) begin
					w_NextState = rxCfg1;
				end
			end
			rxFrame: begin
				if (i_CodeGroup.kind == osT || i_CodeGroup.kind == osR) begin
					w_NextState = rxIdle;
				end else if (i_CodeGroup.kind == osComma) begin
					w_NextState = rxIdle; // early end, frame lost its /T/
				end else begin
					w_Dv = 1'b1;
					w8_Rxd = i_CodeGroup.cg;
					// /V/, stray K groups and invalid groups all corrupt the byte
					w_Er = i_CodeGroup.kind == osV || i_CodeGroup.ctrl || i_CodeGroup.invalid;
				end
			end
			rxCfg1: begin
				if (w_IsData) begin
					w_NextState = rxCfg2;
					w_LoadLow = 1'b1;
				end else begin
					w_NextState = rxIdle; // capture aborted
				end
			end
			rxCfg2: begin
				w_NextState = rxIdle;
				w_CfgValid = w_IsData;
			end
			default: w_NextState = rxIdle;
			endcase
		end
	end

	// idle flag follows the most recent ordered set
	always_comb begin
		w_Idle = o_RxIdle;
		if (!i_CodeGroup.sync) begin
			w_Idle = 1'b0;
		end else begin
			case (i_CodeGroup.kind)
			osI1, osI2:                   w_Idle = 1'b1;
			osC1, osC2, osS, osT, osR, osV: w_Idle = 1'b0;
			default:                      w_Idle = o_RxIdle; // comma or plain data
			endcase
		end
	end

	always_ff @(posedge i_Clk or negedge i_ARst_L) begin
		if (!i_ARst_L) begin
			r_State <= rxIdle;
			o_RxDv <= 1'b0;
			o_RxEr <= 1'b0;
			o_ConfigValid <= 1'b0;
			o_RxIdle <= 1'b0;
		end else if (i_Cke) begin
			r_State <= w_NextState;
			o_RxDv <= w_Dv;
			o_RxEr <= w_Er;
			o_ConfigValid <= w_CfgValid; // single-cycle pulse
			o_RxIdle <= w_Idle;
		end
	end

	always_ff @(posedge i_Clk) begin
		if (i_Cke) begin
			o8_Rxd <= w8_Rxd;
			if (w_LoadLow)
				r8_CfgLow <= i_CodeGroup.cg;
			if (w_CfgValid)
				o16_ConfigWord <= {i_CodeGroup.cg, r8_CfgLow}; // little endian on the line
		end
	end

endmodule

`default_nettype wire

// File: pcsSync.sv
// pcs sync: comma-based code-group alignment, bit-slip request and ordered-set labelling
`timescale 1ns/1ps
`include "pcs_consts.svh"
`default_nettype none

module pcsSync (
	input  wire         i_Clk,
	input  wire         i_ARst_L,
	input  wire         i_Cke,
	input  wire         i_CtrlLoopBack,
	input  wire         i_SignalDetect,
	input  wire  [7:0]  i8_RxCodeGroup,
	input  wire         i_RxCodeCtrl,
	input  wire         i_RxCodeInvalid,
	output logic        o_BitSlip,
	codeGroupIf.syncSide o_CodeGroup
);
	import pcsSyncPkg::*;
	import pcsRxPkg::*;

	SyncState_t                r_State;
	logic                      r_RxEven;
	logic                      r_SyncStatus;
	logic                      r_LastSignalDetect;
	logic [1:0]                r2_GoodCgs;  // good groups seen in an A state
	logic                      r_PrevComma; // previous group was a comma
	logic [`PCS_SLIP_BITS-1:0] r_SlipTmr;
	logic                      w_IsComma;
	logic                      w_IsData;
	logic                      w_IsCtrl;
	logic                      w_CgBad;
	logic                      w_CommaEven;
	logic                      w_SignalLive;
	logic                      w_SignalDetectChange;
	logic                      w_Good3;
	logic                      w_Realign;
	OrdSet_t                   w_Kind;

	assign w_IsCtrl = i_RxCodeCtrl & ~i_RxCodeInvalid;
	assign w_IsData = ~i_RxCodeCtrl & ~i_RxCodeInvalid;
	assign w_IsComma = w_IsCtrl &&
		(i8_RxCodeGroup == `K28_5 || i8_RxCodeGroup == `K28_1 || i8_RxCodeGroup == `K28_7);
	assign w_CommaEven = w_IsComma & ~r_RxEven; // previous was odd, so this one is even
	assign w_CgBad = i_RxCodeInvalid | (w_IsComma & r_RxEven);
	assign w_SignalLive = i_SignalDetect | i_CtrlLoopBack;
	assign w_SignalDetectChange = r_LastSignalDetect ^ i_SignalDetect;
	assign w_Good3 = (r2_GoodCgs == 2'd2); // third good group in a row

	// main synchronization machine
	always_ff @(posedge i_Clk or negedge i_ARst_L) begin
		if (!i_ARst_L) begin
			r_State <= stLossOfSync;
			r_LastSignalDetect <= 1'b0;
		end else if (i_Cke) begin
			r_LastSignalDetect <= i_SignalDetect;
			if (w_SignalDetectChange && !i_RxCodeInvalid && !i_CtrlLoopBack) begin
				r_State <= stLossOfSync;
			end else begin
				case (r_State)
				stLossOfSync:
					if (w_IsComma && w_SignalLive) r_State <= stCommaDet1;
				stCommaDet1:
					r_State <= w_IsData ? stAcqSync1 : stLossOfSync;
				stAcqSync1:
					if (w_CgBad) r_State <= stLossOfSync;
					else if (w_CommaEven) r_State <= stCommaDet2;
				stCommaDet2:
					r_State <= w_IsData ? stAcqSync2 : stLossOfSync;
				stAcqSync2:
					if (w_CgBad) r_State <= stLossOfSync;
					else if (w_CommaEven) r_State <= stCommaDet3;
				stCommaDet3:
					r_State <= w_IsData ? stSyncAcq1 : stLossOfSync;
				stSyncAcq1:
					if (w_CgBad) r_State <= stSyncAcq2;
				stSyncAcq2:
					r_State <= w_CgBad ? stSyncAcq3 : stSyncAcq2A;
				stSyncAcq2A:
					if (w_CgBad) r_State <= stSyncAcq3;
					else if (w_Good3) r_State <= stSyncAcq1;
				stSyncAcq3:
					r_State <= w_CgBad ? stSyncAcq4 : stSyncAcq3A;
				stSyncAcq3A:
					if (w_CgBad) r_State <= stSyncAcq4;
					else if (w_Good3) r_State <= stSyncAcq2;
				stSyncAcq4:
					r_State <= w_CgBad ? stLossOfSync : stSyncAcq4A;
				stSyncAcq4A:
					if (w_CgBad) r_State <= stLossOfSync;
					else if (w_Good3) r_State <= stSyncAcq3;
				default:
					r_State <= stLossOfSync;
				endcase
			end
		end
	end

	// even/odd realigns on every comma accepted during acquisition
	assign w_Realign = (r_State == stLossOfSync && w_IsComma && w_SignalLive) ||
		((r_State == stAcqSync1 || r_State == stAcqSync2) && w_CommaEven);

	always_ff @(posedge i_Clk or negedge i_ARst_L) begin
		if (!i_ARst_L) begin
			r_RxEven <= 1'b0;
			r_SyncStatus <= 1'b0;
			r2_GoodCgs <= 2'd0;
			r_SlipTmr <= '0;
		end else if (i_Cke) begin
			r_RxEven <= w_Realign ? 1'b1 : ~r_RxEven;
			if (r_State == stSyncAcq1)
				r_SyncStatus <= 1'b1;
			else if (r_State == stLossOfSync)
				r_SyncStatus <= 1'b0;
			case (r_State)
			stSyncAcq2, stSyncAcq3, stSyncAcq4:
				r2_GoodCgs <= w_CgBad ? 2'd0 : 2'd1;
			stSyncAcq2A, stSyncAcq3A, stSyncAcq4A:
				r2_GoodCgs <= (w_CgBad || w_Good3) ? 2'd0 : r2_GoodCgs + 2'd1;
			default:
				r2_GoodCgs <= 2'd0;
			endcase
			if (r_State != stLossOfSync || w_IsComma)
				r_SlipTmr <= '0;
			else
				r_SlipTmr <= r_SlipTmr + 1'b1; // wraps, so the request repeats
		end
	end

	assign o_BitSlip = &r_SlipTmr;

	// ordered-set label of the incoming group
	always_comb begin
		w_Kind = osNone;
		if (w_IsComma) begin
			w_Kind = osComma;
		end else if (r_PrevComma && w_IsData) begin
			case (i8_RxCodeGroup)
			`D21_5:  w_Kind = osC1;
			`D2_2:   w_Kind = osC2;
			`D5_6:   w_Kind = osI1;
			`D16_2:  w_Kind = osI2;
			default: w_Kind = osNone;
			endcase
		end else if (w_IsCtrl) begin
			case (i8_RxCodeGroup)
			`K27_7:  w_Kind = osS;
			`K29_7:  w_Kind = osT;
			`K23_7:  w_Kind = osR;
			`K30_7:  w_Kind = osV;
			default: w_Kind = osNone;
			endcase
		end
	end

	always_ff @(posedge i_Clk or negedge i_ARst_L) begin
		if (!i_ARst_L) begin
			r_PrevComma <= 1'b0;
			o_CodeGroup.ctrl <= 1'b0;
			o_CodeGroup.invalid <= 1'b0;
			o_CodeGroup.kind <= osNone;
		end else if (i_Cke) begin
			r_PrevComma <= w_IsComma;
			o_CodeGroup.ctrl <= i_RxCodeCtrl;
			o_CodeGroup.invalid <= i_RxCodeInvalid;
			o_CodeGroup.kind <= w_Kind;
		end
	end

	always_ff @(posedge i_Clk) begin
		if (i_Cke)
			o_CodeGroup.cg <= i8_RxCodeGroup;
	end

	assign o_CodeGroup.even = r_RxEven;
	assign o_CodeGroup.sync = r_SyncStatus;

endmodule

`default_nettype wire

// File: codeGroupIf.sv
// code-group link: one aligned, classified code group per enabled cycle, sync to receive
`timescale 1ns/1ps
`default_nettype none

interface codeGroupIf;
	import pcsRxPkg::*;

	logic [7:0] cg;      // registered code-group byte
	logic       ctrl;    // K group
	logic       invalid; // decoder flagged the group
	OrdSet_t    kind;    // ordered-set label of this same group
	logic       even;    // group sits in an even position
	logic       sync;    // sync status at the time of this group

	modport syncSide (
		output cg,
		output ctrl,
		output invalid,
		output kind,
		output even,
		output sync
	);

	modport rxSide (
		input cg,
		input ctrl,
		input invalid,
		input kind,
		input even,
		input sync
	);

endinterface

`default_nettype wire

// File: pcsRxPkg.sv
// pcs receive package: ordered-set kinds and receive state encoding
`default_nettype none

package pcsRxPkg;

	// kind of the code group on the sync-to-receive link
	typedef enum logic [3:0] {
		osNone,
		osComma, // first group of /C/ or /I/
		osC1,
		osC2,
		osI1,
		osI2,
		osS,
		osT,
		osR,
		osV
	} OrdSet_t;

	typedef enum logic [1:0] {
		rxIdle,
		rxCfg1, // waiting for config low byte
		rxCfg2, // waiting for config high byte
		rxFrame
	} RxState_t;

endpackage

`default_nettype wire

// File: pcsSyncPkg.sv
// pcs sync package: state encoding of the comma synchronization machine
`default_nettype none

package pcsSyncPkg;

	// one-hot, one bit per state
	typedef enum logic [12:0] {
		stLossOfSync = 13'h0001,
		stCommaDet1  = 13'h0002,
		stAcqSync1   = 13'h0004,
		stCommaDet2  = 13'h0008,
		stAcqSync2   = 13'h0010,
		stCommaDet3  = 13'h0020,
		stSyncAcq1   = 13'h0040, // fully in sync
		stSyncAcq2   = 13'h0080,
		stSyncAcq2A  = 13'h0100,
		stSyncAcq3   = 13'h0200,
		stSyncAcq3A  = 13'h0400,
		stSyncAcq4   = 13'h0800,
		stSyncAcq4A  = 13'h1000  // one more bad group drops sync
	} SyncState_t;

endpackage

`default_nettype wire

// File: pcs_consts.svh
// pcs constants: 8b/10b code-group byte values and receive-path sizes
`ifndef PCS_CONSTS_SVH
`define PCS_CONSTS_SVH
`default_nettype none

// comma-bearing special groups
`define K28_5 8'hBC
`define K28_1 8'h3C
`define K28_7 8'hFC

// second group of two-group ordered sets
`define D21_5 8'hB5 // /C1/
`define D2_2  8'h42 // /C2/
`define D5_6  8'hC5 // /I1/
`define D16_2 8'h50 // /I2/

// single-group control ordered sets
`define K23_7 8'hF7 // /R/ carrier extend
`define K27_7 8'hFB // /S/ start of packet
`define K29_7 8'hFD // /T/ end of packet
`define K30_7 8'hFE // /V/ error propagation

// bit-slip request fires when this many timer bits are all set
`define PCS_SLIP_BITS 4

// gmii byte presented in place of /S/
`define PCS_PREAMBLE 8'h55

`default_nettype wire
`endif
